// File: source/cp0_pkg.sv
package cp0_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   // One data or address word
   typedef logic [31:0] word_t;

   // Exception code as carried down the pipeline
   typedef logic [31:0] except_t;

   // CP0 register number
   typedef logic [4:0] cp0_addr_t;

   // External hardware interrupt lines
   typedef logic [5:0] irq_t;

   //////////////////////////////
   // Exception codes
   //////////////////////////////

   localparam except_t exc_none = 32'h0000_0000;
   // Interrupt marker, stored as ExcCode 0
   localparam except_t exc_int  = 32'h0000_0001;
   localparam except_t exc_adel = 32'h0000_0004;
   localparam except_t exc_ades = 32'h0000_0005;
   localparam except_t exc_sys  = 32'h0000_0008;
   localparam except_t exc_bp   = 32'h0000_0009;
   localparam except_t exc_ri   = 32'h0000_000a;
   localparam except_t exc_ov   = 32'h0000_000c;

   //////////////////////////////
   // Register numbers
   //////////////////////////////

   localparam cp0_addr_t cp0_badvaddr = 5'd8;
   localparam cp0_addr_t cp0_count    = 5'd9;
   localparam cp0_addr_t cp0_compare  = 5'd11;
   localparam cp0_addr_t cp0_status   = 5'd12;
   localparam cp0_addr_t cp0_cause    = 5'd13;
   localparam cp0_addr_t cp0_epc      = 5'd14;

   // Boot exception vector, shared by every exception
   localparam word_t exc_vector = 32'hbfc0_0380;

   // Exception level of the control FSM
   typedef enum logic {
      mode_normal    = 1'b0,
      mode_exception = 1'b1
   } mode_t;

endpackage

// File: source/exception_translate.sv
`timescale 1ns/1ns

module exception_translate (
   input  logic             int_req,
   input  logic             ri,
   input  logic             brk,
   input  logic             syscall,
   input  logic             overflow,
   input  logic             addr_error_sw,
   input  logic             addr_error_lw,
   input  logic             pc_error,
   output cp0_pkg::except_t except_type
);

   import cp0_pkg::*;

   // Fixed priority, highest first
   always_comb begin
      if (int_req) begin
         except_type = exc_int;
      end else if (addr_error_lw || pc_error) begin
         // Fetch and load address errors share one code
         except_type = exc_adel;
      end else if (ri) begin
         except_type = exc_ri;
      end else if (syscall) begin
         except_type = exc_sys;
      end else if (brk) begin
         except_type = exc_bp;
      end else if (addr_error_sw) begin
         except_type = exc_ades;
      end else if (overflow) begin
         except_type = exc_ov;
      end else begin
         except_type = exc_none;
      end
   end

endmodule

// File: source/exception_control.sv
`timescale 1ns/1ns

module exception_control (
   input  logic             clk,
   input  logic             rst,
   input  logic             eret,
   input  cp0_pkg::except_t except_type,
   input  cp0_pkg::irq_t    int_hw,
   input  logic             timer_irq,
   input  logic [7:0]       status_im,
   input  logic             status_ie,
   input  logic [1:0]       cause_ip_sw,
   input  cp0_pkg::word_t   epc,
   output logic             int_req,
   output logic             take_exception,
   output logic             take_eret,
   output logic             exception_level,
   output logic             flush,
   output logic             pc_trap,
   output cp0_pkg::word_t   pc_except
);

   import cp0_pkg::*;

   mode_t      mode_q;
   mode_t      mode_d;
   logic [7:0] pending;

   //////////////////////////////
   // Interrupt gating
   //////////////////////////////

   // IP7 carries the timer, IP1..0 are the software bits
   assign pending = {timer_irq, int_hw[4:0], cause_ip_sw};

   assign int_req = (|(pending & status_im)) && status_ie && (mode_q == mode_normal);

   //////////////////////////////
   // Exception level FSM
   //////////////////////////////

   // ERET wins over a fault raised in the same cycle
   assign take_eret      = eret;
   assign take_exception = (except_type != exc_none) && !eret;

   always_comb begin
      mode_d = mode_q;
      if (take_eret) begin
         mode_d = mode_normal;
      end else if (take_exception) begin
         mode_d = mode_exception;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         mode_q <= mode_normal;
      end else begin
         mode_q <= mode_d;
      end
   end

   assign exception_level = (mode_q == mode_exception);

   //////////////////////////////
   // Flush and redirect
   //////////////////////////////

   always_comb begin
      flush     = 1'b0;
      pc_trap   = 1'b0;
      pc_except = '0;
      if (take_eret) begin
         flush     = 1'b1;
         pc_trap   = 1'b1;
         pc_except = epc;
      end else if (take_exception) begin
         flush     = 1'b1;
         pc_trap   = 1'b1;
         pc_except = exc_vector;
      end
   end

endmodule

// File: source/cp0_timer.sv
`timescale 1ns/1ns

module cp0_timer #(
   parameter int unsigned timer_div = 2
) (
   input  logic           clk,
   input  logic           rst,
   input  logic           count_we,
   input  logic           compare_we,
   input  cp0_pkg::word_t wdata,
   output cp0_pkg::word_t count,
   output cp0_pkg::word_t compare,
   output logic           timer_irq
);

   localparam int unsigned pre_w = (timer_div > 1) ? $clog2(timer_div) : 1;
   localparam logic [pre_w-1:0] pre_last = pre_w'(timer_div - 1);

   logic [pre_w-1:0] prescale;
   logic             tick;

   // One tick every timer_div cycles
   assign tick = (prescale == pre_last);

   always_ff @(posedge clk) begin
      if (rst) begin
         prescale <= '0;
      end else if (tick) begin
         prescale <= '0;
      end else begin
         prescale <= prescale + 1'b1;
      end
   end

   // Count and Compare, a write takes precedence over the tick
   always_ff @(posedge clk) begin
      if (rst) begin
         count   <= '0;
         compare <= '0;
      end else begin
         if (count_we) begin
            count <= wdata;
         end else if (tick) begin
            count <= count + 32'd1;
         end
         if (compare_we) begin
            compare <= wdata;
         end
      end
   end

   // Match latch, held until software rewrites Compare
   always_ff @(posedge clk) begin
      if (rst) begin
         timer_irq <= 1'b0;
      end else if (compare_we) begin
         timer_irq <= 1'b0;
      end else if (count == compare) begin
         timer_irq <= 1'b1;
      end
   end

endmodule

// File: source/cp0_registers.sv
`timescale 1ns/1ns

module cp0_registers (
   input  logic              clk,
   input  logic              rst,
   input  logic              take_exception,
   input  logic              take_eret,
   input  logic              exception_level,
   input  logic              in_delay_slot,
   input  logic              cp0_we,
   input  cp0_pkg::except_t  except_type,
   input  cp0_pkg::word_t    pc_m,
   input  cp0_pkg::word_t    bad_addr,
   input  cp0_pkg::word_t    cp0_wdata,
   input  cp0_pkg::word_t    count,
   input  cp0_pkg::word_t    compare,
   input  cp0_pkg::cp0_addr_t cp0_waddr,
   input  cp0_pkg::cp0_addr_t cp0_raddr,
   input  cp0_pkg::irq_t     int_hw,
   input  logic              timer_irq,
   output cp0_pkg::word_t    cp0_rdata,
   output logic [7:0]        status_im,
   output logic              status_ie,
   output logic [1:0]        cause_ip_sw,
   output cp0_pkg::word_t    epc,
   output logic              count_we,
   output logic              compare_we
);

   import cp0_pkg::*;

   logic        wr_ok;
   logic        cause_bd;
   logic [4:0]  cause_exc;
   word_t       badvaddr;
   word_t       status_word;
   word_t       cause_word;
   logic        fetch_fault;

   //////////////////////////////
   // Write decode
   //////////////////////////////

   // A flushing cycle drops the write
   assign wr_ok      = cp0_we && !take_exception && !take_eret;
   assign count_we   = wr_ok && (cp0_waddr == cp0_count);
   assign compare_we = wr_ok && (cp0_waddr == cp0_compare);

   // Status keeps IM and IE only
   always_ff @(posedge clk) begin
      if (rst) begin
         status_im <= '0;
         status_ie <= 1'b0;
      end else if (wr_ok && (cp0_waddr == cp0_status)) begin
         status_im <= cp0_wdata[15:8];
         status_ie <= cp0_wdata[0];
      end
   end

   //////////////////////////////
   // Exception capture
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         cause_bd    <= 1'b0;
         cause_exc   <= '0;
         cause_ip_sw <= '0;
         epc         <= '0;
      end else if (take_exception) begin
         cause_bd  <= in_delay_slot;
         // Interrupts are recorded as code 0
         cause_exc <= (except_type == exc_int) ? 5'd0 : except_type[4:0];
         epc       <= in_delay_slot ? (pc_m - 32'd4) : pc_m;
      end else begin
         if (wr_ok && (cp0_waddr == cp0_cause)) begin
            cause_ip_sw <= cp0_wdata[9:8];
         end
         if (wr_ok && (cp0_waddr == cp0_epc)) begin
            epc <= cp0_wdata;
         end
      end
   end

   // A misaligned PC marks the address error as a fetch fault
   assign fetch_fault = (pc_m[1:0] != 2'b00);

   always_ff @(posedge clk) begin
      if (take_exception) begin
         if ((except_type == exc_adel) && fetch_fault) begin
            badvaddr <= pc_m;
         end else if ((except_type == exc_adel) || (except_type == exc_ades)) begin
            badvaddr <= bad_addr;
         end
      end
   end

   //////////////////////////////
   // Read multiplexer
   //////////////////////////////

   assign status_word = {16'b0, status_im, 6'b0, exception_level, status_ie};

   // Live hardware lines in IP, timer on bit 15
   assign cause_word = {cause_bd, 15'b0, timer_irq, int_hw[4:0], cause_ip_sw,
                        1'b0, cause_exc, 2'b00};

   always_comb begin
      case (cp0_raddr)
         cp0_badvaddr: cp0_rdata = badvaddr;
         cp0_count:    cp0_rdata = count;
         cp0_compare:  cp0_rdata = compare;
         cp0_status:   cp0_rdata = status_word;
         cp0_cause:    cp0_rdata = cause_word;
         cp0_epc:      cp0_rdata = epc;
         default:      cp0_rdata = '0;
      endcase
   end

endmodule

// File: source/exception_unit.sv
`timescale 1ns/1ns

module exception_unit #(
   parameter int unsigned timer_div = 2
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               ri,
   input  logic               brk,
   input  logic               syscall,
   input  logic               overflow,
   input  logic               addr_error_lw,
   input  logic               addr_error_sw,
   input  logic               pc_error,
   input  logic               eret,
   input  logic               in_delay_slot,
   input  cp0_pkg::word_t     pc_m,
   input  cp0_pkg::word_t     bad_addr,
   input  cp0_pkg::irq_t      int_hw,
   input  logic               cp0_we,
   input  cp0_pkg::cp0_addr_t cp0_waddr,
   input  cp0_pkg::word_t     cp0_wdata,
   input  cp0_pkg::cp0_addr_t cp0_raddr,
   output cp0_pkg::word_t     cp0_rdata,
   output logic               flush,
   output logic               pc_trap,
   output cp0_pkg::word_t     pc_except,
   output cp0_pkg::except_t   except_type
);

   import cp0_pkg::*;

   logic       int_req;
   logic       take_exception;
   logic       take_eret;
   logic       exception_level;
   logic [7:0] status_im;
   logic       status_ie;
   logic [1:0] cause_ip_sw;
   word_t      epc;
   logic       timer_irq;
   word_t      count;
   word_t      compare;
   logic       count_we;
   logic       compare_we;

   exception_translate u_exception_translate (
      .int_req       (int_req),
      .ri            (ri),
      .brk           (brk),
      .syscall       (syscall),
      .overflow      (overflow),
      .addr_error_sw (addr_error_sw),
      .addr_error_lw (addr_error_lw),
      .pc_error      (pc_error),
      .except_type   (except_type)
   );

   exception_control u_exception_control (
      .clk             (clk),
      .rst             (rst),
      .eret            (eret),
      .except_type     (except_type),
      .int_hw          (int_hw),
      .timer_irq       (timer_irq),
      .status_im       (status_im),
      .status_ie       (status_ie),
      .cause_ip_sw     (cause_ip_sw),
      .epc             (epc),
      .int_req         (int_req),
      .take_exception  (take_exception),
      .take_eret       (take_eret),
      .exception_level (exception_level),
      .flush           (flush),
      .pc_trap         (pc_trap),
      .pc_except       (pc_except)
   );

   cp0_timer #(
      .timer_div (timer_div)
   ) u_cp0_timer (
      .clk        (clk),
      .rst        (rst),
      .count_we   (count_we),
      .compare_we (compare_we),
      .wdata      (cp0_wdata),
      .count      (count),
      .compare    (compare),
      .timer_irq  (timer_irq)
   );

   cp0_registers u_cp0_registers (
      .clk             (clk),
      .rst             (rst),
      .take_exception  (take_exception),
      .take_eret       (take_eret),
      .exception_level (exception_level),
      .in_delay_slot   (in_delay_slot),
      .cp0_we          (cp0_we),
      .except_type     (except_type),
      .pc_m            (pc_m),
      .bad_addr        (bad_addr),
      .cp0_wdata       (cp0_wdata),
      .count           (count),
      .compare         (compare),
      .cp0_waddr       (cp0_waddr),
      .cp0_raddr       (cp0_raddr),
      .int_hw          (int_hw),
      .timer_irq       (timer_irq),
      .cp0_rdata       (cp0_rdata),
      .status_im       (status_im),
      .status_ie       (status_ie),
      .cause_ip_sw     (cause_ip_sw),
      .epc             (epc),
      .count_we        (count_we),
      .compare_we      (compare_we)
   );

endmodule

// File: verification/exception_unit_tb.sv
`timescale 1ns/1ns

module exception_unit_tb;

   import cp0_pkg::*;

   localparam int half_period = 50;

   logic        clk = 1'b0;
   logic        rst = 1'b1;
   // Fault flags ri brk syscall overflow lw sw pc from bit 6 down
   logic [6:0]  flt = '0;
   logic        eret = 1'b0;
   logic        in_delay_slot = 1'b0;
   word_t       pc_m = '0;
   word_t       bad_addr = '0;
   irq_t        int_hw = '0;
   logic        cp0_we = 1'b0;
   cp0_addr_t   cp0_waddr = '0;
   word_t       cp0_wdata = '0;
   cp0_addr_t   cp0_raddr = '0;
   word_t       cp0_rdata;
   logic        flush;
   logic        pc_trap;
   word_t       pc_except;
   except_t     except_type;

   logic [31:0] rng_state = 32'd92978;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   string       test_name = "reset";
   logic        check_en = 1'b0;

   // Model of the CP0 state that steers the redirect
   logic [7:0]  m_im = '0;
   logic        m_ie = 1'b0;
   logic        m_exl = 1'b0;
   word_t       m_epc = '0;
   logic        int_on;
   logic [63:0] expect_word;
   logic        exp_flush;

   exception_unit #(
      .timer_div (2)
   ) u_exception_unit (
      .clk           (clk),
      .rst           (rst),
      .ri            (flt[6]),
      .brk           (flt[5]),
      .syscall       (flt[4]),
      .overflow      (flt[3]),
      .addr_error_lw (flt[2]),
      .addr_error_sw (flt[1]),
      .pc_error      (flt[0]),
      .eret          (eret),
      .in_delay_slot (in_delay_slot),
      .pc_m          (pc_m),
      .bad_addr      (bad_addr),
      .int_hw        (int_hw),
      .cp0_we        (cp0_we),
      .cp0_waddr     (cp0_waddr),
      .cp0_wdata     (cp0_wdata),
      .cp0_raddr     (cp0_raddr),
      .cp0_rdata     (cp0_rdata),
      .flush         (flush),
      .pc_trap       (pc_trap),
      .pc_except     (pc_except),
      .except_type   (except_type)
   );

   always #half_period clk = ~clk;

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic word_t next_random();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state;
   endfunction

   // Expected code and redirect target packed as {code, target}
   function automatic logic [63:0] predict_outcome(input logic [6:0] f, input logic eret_i,
                                                   input logic int_on_i, input word_t epc_i);
      except_t code;
      word_t   target;
      if (int_on_i) begin
         code = exc_int;
      end else if (f[2] || f[0]) begin
         code = exc_adel;
      end else if (f[6]) begin
         code = exc_ri;
      end else if (f[4]) begin
         code = exc_sys;
      end else if (f[5]) begin
         code = exc_bp;
      end else if (f[1]) begin
         code = exc_ades;
      end else if (f[3]) begin
         code = exc_ov;
      end else begin
         code = exc_none;
      end
      if (eret_i) begin
         target = epc_i;
      end else if (code != exc_none) begin
         target = exc_vector;
      end else begin
         target = '0;
      end
      return {code, target};
   endfunction

   task automatic check_value(input string what, input word_t expected, input word_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH %s %s: expected %h actual %h", test_name, what, expected, actual);
      end
   endtask

   task automatic write_reg(input cp0_addr_t addr, input word_t data);
      @(negedge clk);
      flt = '0;
      eret = 1'b0;
      cp0_we = 1'b1;
      cp0_waddr = addr;
      cp0_wdata = data;
      cp0_raddr = addr;
      @(negedge clk);
      cp0_we = 1'b0;
   endtask

   task automatic read_reg(input cp0_addr_t addr, output word_t data);
      @(negedge clk);
      cp0_raddr = addr;
      #1;
      data = cp0_rdata;
   endtask

   // One-cycle fault from the memory stage
   task automatic raise_fault(input logic [6:0] f, input word_t pc, input word_t addr,
                              input logic ds);
      @(negedge clk);
      flt = f;
      pc_m = pc;
      bad_addr = addr;
      in_delay_slot = ds;
      @(negedge clk);
      flt = '0;
      in_delay_slot = 1'b0;
   endtask

   task automatic return_from_exception();
      @(negedge clk);
      flt = '0;
      eret = 1'b1;
      @(negedge clk);
      eret = 1'b0;
   endtask

   task automatic end_test(input int err_start);
      tests++;
      if (errors == err_start) begin
         $display("test %s: ok", test_name);
      end else begin
         $display("test %s: %0d errors", test_name, errors - err_start);
      end
   endtask

   //////////////////////////////
   // Comparing process
   //////////////////////////////

   // Sample one ns before the rising edge and step the model across it
   always begin
      @(negedge clk);
      #(half_period - 1);
      int_on = (|({int_hw[4:0], 2'b00} & m_im[6:0])) && m_ie && !m_exl;
      expect_word = predict_outcome(flt, eret, int_on, m_epc);
      exp_flush = eret || (expect_word[63:32] != exc_none);
      if (!rst && check_en) begin
         check_value("except_type", expect_word[63:32], except_type);
         check_value("flush", {31'b0, exp_flush}, {31'b0, flush});
         check_value("pc_trap", {31'b0, exp_flush}, {31'b0, pc_trap});
         check_value("pc_except", expect_word[31:0], pc_except);
      end
      if (rst) begin
         m_im = '0;
         m_ie = 1'b0;
         m_exl = 1'b0;
         m_epc = '0;
      end else if (eret) begin
         m_exl = 1'b0;
      end else if (exp_flush) begin
         m_exl = 1'b1;
         m_epc = in_delay_slot ? (pc_m - 32'd4) : pc_m;
      end else if (cp0_we && (cp0_waddr == cp0_status)) begin
         m_im = cp0_wdata[15:8];
         m_ie = cp0_wdata[0];
      end else if (cp0_we && (cp0_waddr == cp0_epc)) begin
         m_epc = cp0_wdata;
      end
   end

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      word_t     r;
      word_t     v;
      word_t     rd;
      word_t     prev;
      cp0_addr_t a;
      int        i;
      int        n;
      int        err_start;

      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_en = 1'b1;

      // Random flags with interrupts masked
      test_name = "priority";
      err_start = errors;
      for (i = 0; i < 220; i++) begin
         @(negedge clk);
         r = next_random();
         flt = r[30:24] & r[22:16];
         eret = (r[15:13] == 3'b000);
         in_delay_slot = r[11];
         pc_m = next_random();
         bad_addr = next_random();
      end
      return_from_exception();
      end_test(err_start);

      test_name = "capture";
      err_start = errors;
      raise_fault(7'b0000100, 32'h8000_1004, 32'h1234_5671, 1'b1);
      read_reg(cp0_epc, v);
      check_value("epc", 32'h8000_1000, v);
      read_reg(cp0_cause, v);
      check_value("cause", 32'h8000_0010, v & 32'h8000_007c);
      read_reg(cp0_badvaddr, v);
      check_value("badvaddr", 32'h1234_5671, v);
      read_reg(cp0_status, v);
      check_value("status exl", 32'h0000_0002, v & 32'h0000_0002);
      return_from_exception();
      // BadVAddr takes the PC on a misaligned fetch
      raise_fault(7'b0000001, 32'h8000_2002, 32'h0000_0000, 1'b0);
      read_reg(cp0_epc, v);
      check_value("epc", 32'h8000_2002, v);
      read_reg(cp0_cause, v);
      check_value("cause", 32'h0000_0010, v & 32'h8000_007c);
      read_reg(cp0_badvaddr, v);
      check_value("badvaddr", 32'h8000_2002, v);
      end_test(err_start);

      test_name = "eret";
      err_start = errors;
      @(negedge clk);
      eret = 1'b1;
      flt = 7'b1000000;
      #1;
      check_value("flush", 32'd1, {31'b0, flush});
      check_value("target", 32'h8000_2002, pc_except);
      @(negedge clk);
      eret = 1'b0;
      flt = '0;
      read_reg(cp0_status, v);
      check_value("status exl", 32'h0000_0000, v & 32'h0000_0002);
      end_test(err_start);

      // Line 2 maps to IM4 in Status bit 12
      test_name = "masking";
      err_start = errors;
      @(negedge clk);
      int_hw = 6'b000100;
      write_reg(cp0_status, 32'h0000_1000);
      #1;
      check_value("ie clear", exc_none, except_type);
      write_reg(cp0_status, 32'h0000_2001);
      #1;
      check_value("other line", exc_none, except_type);
      write_reg(cp0_status, 32'h0000_1001);
      #1;
      check_value("enabled", exc_int, except_type);
      @(negedge clk);
      #1;
      check_value("exl set", exc_none, except_type);
      @(negedge clk);
      int_hw = '0;
      read_reg(cp0_cause, v);
      check_value("exccode", 32'h0000_0000, v & 32'h0000_007c);
      write_reg(cp0_status, 32'h0000_0000);
      return_from_exception();
      end_test(err_start);

      test_name = "timer";
      err_start = errors;
      check_en = 1'b0;
      write_reg(cp0_count, 32'd0);
      write_reg(cp0_compare, 32'd40);
      read_reg(cp0_cause, v);
      check_value("pending cleared", 32'h0000_0000, v & 32'h0000_8000);
      prev = '0;
      for (i = 0; i < 6; i++) begin
         read_reg(cp0_count, v);
         checks++;
         if (v < prev) begin
            errors++;
            $display("count went backwards from %h to %h", prev, v);
         end
         prev = v;
      end
      write_reg(cp0_status, 32'h0000_8001);
      #1;
      n = 0;
      while ((except_type != exc_int) && (n < 400)) begin
         @(negedge clk);
         #1;
         n++;
      end
      if (except_type != exc_int) begin
         errors++;
         $display("timer interrupt not taken within %0d cycles", n);
      end else begin
         read_reg(cp0_cause, v);
         check_value("timer cause", 32'h0000_8000, v & 32'h0000_807c);
      end
      write_reg(cp0_compare, 32'hffff_0000);
      read_reg(cp0_cause, v);
      check_value("compare write", 32'h0000_0000, v & 32'h0000_8000);
      write_reg(cp0_status, 32'h0000_0000);
      return_from_exception();
      check_en = 1'b1;
      end_test(err_start);

      // IE stays clear so no interrupt fires
      test_name = "registers";
      err_start = errors;
      for (i = 0; i < 24; i++) begin
         r = next_random();
         v = next_random();
         case (r[29:28])
            2'd0: begin
               a = cp0_status;
               v = v & 32'h0000_ff00;
            end
            2'd1: a = cp0_epc;
            default: a = cp0_compare;
         endcase
         write_reg(a, v);
         // Read right after the writing edge
         #1;
         rd = cp0_rdata;
         check_value($sformatf("reg %0d", a), v, rd);
      end
      write_reg(cp0_status, 32'h0000_0000);
      end_test(err_start);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: compile.f
source/cp0_pkg.sv
source/exception_translate.sv
source/exception_control.sv
source/cp0_timer.sv
source/cp0_registers.sv
source/exception_unit.sv
verification/exception_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exception_unit_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "no result found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
